// File: all.f
+incdir+hw
hw/cpuPkg.sv
hw/opDecoder.sv
hw/aluUnit.sv
hw/coreSequencer.sv
hw/memArbiter.sv
hw/ramBlock.sv
hw/cpuTop.sv
verif/cpuTbAsserts.sv
verif/cpuTb.sv

// File: hw/aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
    input  cpuPkg::cmdE cmd,
    input  logic [7:0]  regA,
    input  logic [7:0]  regX,
    input  logic [7:0]  regY,
    input  logic [7:0]  operand,
    input  logic        carryIn,
    output logic [7:0]  result,
    output logic        nFlag,
    output logic        zFlag,
    output logic        cFlag,
    output logic [1:0]  writesReg
);

    logic [8:0] sum;

    assign sum = {1'b0, regA} + {1'b0, operand} + {8'd0, carryIn};

    always_comb begin
        case (cmd)
            cpuPkg::LDA, cpuPkg::LDX, cpuPkg::LDY: result = operand;
            cpuPkg::STA, cpuPkg::TAX, cpuPkg::TAY: result = regA; // stores drive wdata
            cpuPkg::STX, cpuPkg::TXA:              result = regX;
            cpuPkg::STY, cpuPkg::TYA:              result = regY;
            cpuPkg::ADC: result = sum[7:0];
            cpuPkg::AND: result = regA & operand;
            cpuPkg::ORA: result = regA | operand;
            cpuPkg::EOR: result = regA ^ operand;
            cpuPkg::INX: result = regX + 8'd1;
            cpuPkg::DEX: result = regX - 8'd1;
            cpuPkg::INY: result = regY + 8'd1;
            cpuPkg::DEY: result = regY - 8'd1;
            default:     result = 8'h00;
        endcase

        case (cmd)
            cpuPkg::LDA, cpuPkg::ADC, cpuPkg::AND, cpuPkg::ORA, cpuPkg::EOR,
            cpuPkg::TXA, cpuPkg::TYA: writesReg = cpuPkg::WR_A;
            cpuPkg::LDX, cpuPkg::INX, cpuPkg::DEX, cpuPkg::TAX: writesReg = cpuPkg::WR_X;
            cpuPkg::LDY, cpuPkg::INY, cpuPkg::DEY, cpuPkg::TAY: writesReg = cpuPkg::WR_Y;
            default: writesReg = cpuPkg::WR_NONE;
        endcase

        case (cmd)
            cpuPkg::ADC: cFlag = sum[8];
            cpuPkg::CLC: cFlag = 1'b0;
            cpuPkg::SEC: cFlag = 1'b1;
            default:     cFlag = carryIn; // carry untouched
        endcase
    end

    assign nFlag = result[7];
    assign zFlag = (result == 8'h00);

endmodule

// File: hw/coreSequencer.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module coreSequencer (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      start,
    output logic                      coreReq,
    output logic                      coreWe,
    output logic [`MEM_ADDR_BITS-1:0] coreAddr,
    output logic [7:0]                coreWdata,
    input  logic                      coreGrant,
    input  logic [7:0]                coreRdata,
    input  cpuPkg::cmdE               cmd,
    input  cpuPkg::addrModeE          addrMode,
    input  logic [7:0]                aluResult,
    input  logic                      aluN,
    input  logic                      aluZ,
    input  logic                      aluC,
    input  logic [1:0]                aluWrites,
    output logic [7:0]                opcode,
    output logic [7:0]                regA,
    output logic [7:0]                regX,
    output logic [7:0]                regY,
    output logic [7:0]                operand,
    output logic                      carry,
    output logic                      busy,
    output logic                      done,
    output logic                      illegal
);

    cpuPkg::seqStateE          state;
    logic [`MEM_ADDR_BITS-1:0] pc;
    logic [`MEM_ADDR_BITS-1:0] effAddr;
    logic [`MEM_ADDR_BITS-1:0] branchTarget;
    logic [15:0]               absAddr;
    logic                      dataPhase; // second cycle of a granted access
    logic                      flagZ;
    logic                      isStore;
    logic                      isLegal;
    logic                      branchTaken;

    assign absAddr      = {coreRdata, operand};
    assign branchTarget = pc + {{(`MEM_ADDR_BITS-8){operand[7]}}, operand};
    assign isStore      = cmd inside {cpuPkg::STA, cpuPkg::STX, cpuPkg::STY};
    assign branchTaken  = (cmd == cpuPkg::BNE && !flagZ) || (cmd == cpuPkg::BEQ && flagZ);

    // kept subset of commands and modes
    always_comb begin
        case (cmd)
            cpuPkg::LDA, cpuPkg::LDX, cpuPkg::LDY, cpuPkg::ADC,
            cpuPkg::AND, cpuPkg::ORA, cpuPkg::EOR:
                isLegal = addrMode inside {cpuPkg::IMM, cpuPkg::ZPG, cpuPkg::ABS};
            cpuPkg::STA, cpuPkg::STX, cpuPkg::STY:
                isLegal = addrMode inside {cpuPkg::ZPG, cpuPkg::ABS};
            cpuPkg::INX, cpuPkg::INY, cpuPkg::DEX, cpuPkg::DEY, cpuPkg::TAX, cpuPkg::TAY,
            cpuPkg::TXA, cpuPkg::TYA, cpuPkg::CLC, cpuPkg::SEC, cpuPkg::NOP, cpuPkg::BRK:
                isLegal = (addrMode == cpuPkg::IMPL);
            cpuPkg::JMP:              isLegal = (addrMode == cpuPkg::ABS);
            cpuPkg::BNE, cpuPkg::BEQ: isLegal = (addrMode == cpuPkg::REL);
            default:                  isLegal = 1'b0;
        endcase
    end

    // request held until granted, then one cycle for the read data
    assign coreReq = !dataPhase && (state inside {cpuPkg::FETCH, cpuPkg::OPLO,
                                                  cpuPkg::OPHI, cpuPkg::MEMRD, cpuPkg::MEMWR});
    assign coreWe    = coreReq && (state == cpuPkg::MEMWR);
    assign coreAddr  = (state inside {cpuPkg::MEMRD, cpuPkg::MEMWR}) ? effAddr : pc;
    assign coreWdata = aluResult;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= cpuPkg::IDLE;
            pc        <= '0;
            effAddr   <= '0;
            opcode    <= 8'h00;
            operand   <= 8'h00;
            regA      <= 8'h00;
            regX      <= 8'h00;
            regY      <= 8'h00;
            carry     <= 1'b0;
            flagZ     <= 1'b0;
            dataPhase <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            dataPhase <= coreReq && coreGrant;
            done      <= 1'b0;
            case (state)
                cpuPkg::IDLE: begin
                    if (start) begin
                        pc      <= `RESET_VECTOR;
                        busy    <= 1'b1;
                        illegal <= 1'b0;
                        state   <= cpuPkg::FETCH;
                    end
                end
                cpuPkg::FETCH: begin
                    if (dataPhase) begin
                        opcode <= coreRdata;
                        pc     <= pc + 1'b1;
                        state  <= cpuPkg::DECODE;
                    end
                end
                cpuPkg::DECODE: begin
                    if (!isLegal) begin
                        illegal <= 1'b1;
                        done    <= 1'b1;
                        busy    <= 1'b0;
                        state   <= cpuPkg::HALT;
                    end else if (addrMode == cpuPkg::IMPL) begin
                        state <= cpuPkg::EXEC;
                    end else begin
                        state <= cpuPkg::OPLO;
                    end
                end
                cpuPkg::OPLO: begin
                    if (dataPhase) begin
                        operand <= coreRdata;
                        effAddr <= `MEM_ADDR_BITS'(coreRdata); // zero page
                        pc      <= pc + 1'b1;
                        case (addrMode)
                            cpuPkg::ZPG: state <= isStore ? cpuPkg::MEMWR : cpuPkg::MEMRD;
                            cpuPkg::ABS: state <= cpuPkg::OPHI;
                            default:     state <= cpuPkg::EXEC; // imm, rel
                        endcase
                    end
                end
                cpuPkg::OPHI: begin
                    if (dataPhase) begin
                        effAddr <= absAddr[`MEM_ADDR_BITS-1:0]; // wraps in RAM
                        pc      <= pc + 1'b1;
                        if (cmd == cpuPkg::JMP) begin
                            state <= cpuPkg::EXEC;
                        end else begin
                            state <= isStore ? cpuPkg::MEMWR : cpuPkg::MEMRD;
                        end
                    end
                end
                cpuPkg::MEMRD: begin
                    if (dataPhase) begin
                        operand <= coreRdata;
                        state   <= cpuPkg::EXEC;
                    end
                end
                cpuPkg::MEMWR: begin
                    if (dataPhase) begin
                        state <= cpuPkg::FETCH;
                    end
                end
                cpuPkg::EXEC: begin
                    case (aluWrites)
                        cpuPkg::WR_A: regA <= aluResult;
                        cpuPkg::WR_X: regX <= aluResult;
                        cpuPkg::WR_Y: regY <= aluResult;
                        default:      ;
                    endcase
                    if (aluWrites != cpuPkg::WR_NONE) begin
                        flagZ <= aluZ;
                    end
                    carry <= aluC;
                    state <= cpuPkg::FETCH;
                    if (cmd == cpuPkg::JMP) begin
                        pc <= effAddr;
                    end else if (branchTaken) begin
                        pc <= branchTarget;
                    end else if (cmd == cpuPkg::BRK) begin
                        done  <= 1'b1;
                        busy  <= 1'b0;
                        state <= cpuPkg::HALT;
                    end
                end
                cpuPkg::HALT: state <= cpuPkg::IDLE;
                default:      state <= cpuPkg::IDLE;
            endcase
        end
    end

endmodule

// File: hw/cpuPkg.sv
package cpuPkg;

    // every mnemonic the decoder can emit, accumulator forms included
    typedef enum logic [5:0] {
        BRK, JSR, RTI, RTS, LDY, CPY, CPX, BIT,
        STY, PHP, PLP, PHA, PLA, DEY, TAY, INY,
        INX, JMP, BPL, BMI, BVC, BVS, BCC, BCS,
        BNE, BEQ, CLC, SEC, CLI, SEI, TYA, CLV,
        CLD, SED, ORA, AND, EOR, ADC, STA, LDA,
        CMP, SBC, LDX, ASL, ROL, LSR, ROR, STX,
        DEC, INC, ASLA, ROLA, LSRA, RORA, TXA, TAX,
        DEX, NOP, TXS, TSX
    } cmdE;

    typedef enum logic [3:0] {
        IMPL, ACC, IMM, ZPG, ZPGX, ZPGY, ABS,
        ABSX, ABSY, IND, XIND, INDY, REL
    } addrModeE;

    typedef enum logic [3:0] {
        IDLE, FETCH, DECODE, OPLO, OPHI, MEMRD, MEMWR, EXEC, HALT
    } seqStateE;

    // destination register of an ALU result
    typedef enum logic [1:0] {
        WR_NONE, WR_A, WR_X, WR_Y
    } wrSelE;

endpackage

// File: hw/cpuTop.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpuTop (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      start,
    input  logic                      hostReq,
    input  logic                      hostWe,
    input  logic [`MEM_ADDR_BITS-1:0] hostAddr,
    input  logic [7:0]                hostWdata,
    output logic [7:0]                hostRdata,
    output logic                      busy,
    output logic                      done,
    output logic                      illegal
);

    logic                      coreReq;
    logic                      coreWe;
    logic [`MEM_ADDR_BITS-1:0] coreAddr;
    logic [7:0]                coreWdata;
    logic                      coreGrant;
    logic                      ramEn;
    logic                      ramWe;
    logic [`MEM_ADDR_BITS-1:0] ramAddr;
    logic [7:0]                ramWdata;
    logic [7:0]                ramRdata;
    cpuPkg::cmdE               cmd;
    cpuPkg::addrModeE          addrMode;
    logic [7:0]                opcode;
    logic [7:0]                regA;
    logic [7:0]                regX;
    logic [7:0]                regY;
    logic [7:0]                operand;
    logic                      carry;
    logic [7:0]                aluResult;
    logic                      aluN;
    logic                      aluZ;
    logic                      aluC;
    logic [1:0]                aluWrites;

    assign hostRdata = ramRdata; // shared read bus

    coreSequencer u_coreSequencer (
        .clk, .arstN, .start,
        .coreReq, .coreWe, .coreAddr, .coreWdata, .coreGrant,
        .coreRdata (ramRdata),
        .cmd, .addrMode, .aluResult, .aluN, .aluZ, .aluC, .aluWrites,
        .opcode, .regA, .regX, .regY, .operand, .carry,
        .busy, .done, .illegal
    );

    opDecoder u_opDecoder (
        .opcode, .cmd, .addrMode
    );

    aluUnit u_aluUnit (
        .cmd, .regA, .regX, .regY, .operand,
        .carryIn   (carry),
        .result    (aluResult),
        .nFlag     (aluN),
        .zFlag     (aluZ),
        .cFlag     (aluC),
        .writesReg (aluWrites)
    );

    memArbiter u_memArbiter (
        .hostReq, .hostWe, .hostAddr, .hostWdata,
        .coreReq, .coreWe, .coreAddr, .coreWdata, .coreGrant,
        .ramEn, .ramWe, .ramAddr, .ramWdata
    );

    ramBlock u_ramBlock (
        .clk, .ramEn, .ramWe, .ramAddr, .ramWdata, .ramRdata
    );

endmodule

// File: hw/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// 1024-byte RAM, addresses wrap inside it
`define MEM_ADDR_BITS 10
`define MEM_BYTES     (1 << `MEM_ADDR_BITS)

// first instruction fetched after start
`define RESET_VECTOR  10'h200

`endif

// File: hw/memArbiter.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module memArbiter (
    input  logic                      hostReq,
    input  logic                      hostWe,
    input  logic [`MEM_ADDR_BITS-1:0] hostAddr,
    input  logic [7:0]                hostWdata,
    input  logic                      coreReq,
    input  logic                      coreWe,
    input  logic [`MEM_ADDR_BITS-1:0] coreAddr,
    input  logic [7:0]                coreWdata,
    output logic                      coreGrant,
    output logic                      ramEn,
    output logic                      ramWe,
    output logic [`MEM_ADDR_BITS-1:0] ramAddr,
    output logic [7:0]                ramWdata
);

    // host has fixed priority, core waits
    assign coreGrant = coreReq && !hostReq;

    assign ramEn    = hostReq || coreReq;
    assign ramWe    = hostReq ? hostWe : (coreReq && coreWe);
    assign ramAddr  = hostReq ? hostAddr : coreAddr;
    assign ramWdata = hostReq ? hostWdata : coreWdata;

endmodule

// File: hw/opDecoder.sv
`timescale 1ns/10ps

module opDecoder (
    input  logic [7:0]       opcode,
    output cpuPkg::cmdE      cmd,
    output cpuPkg::addrModeE addrMode
);

    logic [2:0] aaa;
    logic [2:0] bbb;
    logic [1:0] cc;

    assign aaa = opcode[7:5];
    assign bbb = opcode[4:2];
    assign cc  = opcode[1:0];

    // read-modify-write row of the cc=10 group, 100 and 101 are the X moves
    function automatic cpuPkg::cmdE rmwCmd(input logic [2:0] sel);
        case (sel)
            3'b000:  return cpuPkg::ASL;
            3'b001:  return cpuPkg::ROL;
            3'b010:  return cpuPkg::LSR;
            3'b011:  return cpuPkg::ROR;
            3'b100:  return cpuPkg::STX;
            3'b101:  return cpuPkg::LDX;
            3'b110:  return cpuPkg::DEC;
            default: return cpuPkg::INC;
        endcase
    endfunction

    always_comb begin
        cmd      = cpuPkg::BRK;
        addrMode = cpuPkg::IMPL;
        case (cc)
            2'b00: begin
                case (bbb)
                    3'b000: begin
                        addrMode = cpuPkg::IMM;
                        case (aaa)
                            3'b000: addrMode = cpuPkg::IMPL; // BRK
                            3'b001: begin
                                cmd      = cpuPkg::JSR;
                                addrMode = cpuPkg::ABS;
                            end
                            3'b010: begin
                                cmd      = cpuPkg::RTI;
                                addrMode = cpuPkg::IMPL;
                            end
                            3'b011: begin
                                cmd      = cpuPkg::RTS;
                                addrMode = cpuPkg::IMPL;
                            end
                            3'b101:  cmd = cpuPkg::LDY;
                            3'b110:  cmd = cpuPkg::CPY;
                            default: cmd = cpuPkg::CPX;
                        endcase
                    end
                    3'b001, 3'b011: begin
                        addrMode = bbb[1] ? cpuPkg::ABS : cpuPkg::ZPG;
                        case (aaa)
                            3'b001:  cmd = cpuPkg::BIT;
                            3'b010:  cmd = cpuPkg::JMP;
                            3'b011: begin
                                cmd      = cpuPkg::JMP;
                                addrMode = cpuPkg::IND;
                            end
                            3'b100:  cmd = cpuPkg::STY;
                            3'b101:  cmd = cpuPkg::LDY;
                            3'b110:  cmd = cpuPkg::CPY;
                            default: cmd = cpuPkg::CPX;
                        endcase
                    end
                    3'b010: begin
                        case (aaa)
                            3'b000:  cmd = cpuPkg::PHP;
                            3'b001:  cmd = cpuPkg::PLP;
                            3'b010:  cmd = cpuPkg::PHA;
                            3'b011:  cmd = cpuPkg::PLA;
                            3'b100:  cmd = cpuPkg::DEY;
                            3'b101:  cmd = cpuPkg::TAY;
                            3'b110:  cmd = cpuPkg::INY;
                            default: cmd = cpuPkg::INX;
                        endcase
                    end
                    3'b100: begin
                        addrMode = cpuPkg::REL;
                        case (aaa)
                            3'b000:  cmd = cpuPkg::BPL;
                            3'b001:  cmd = cpuPkg::BMI;
                            3'b010:  cmd = cpuPkg::BVC;
                            3'b011:  cmd = cpuPkg::BVS;
                            3'b100:  cmd = cpuPkg::BCC;
                            3'b101:  cmd = cpuPkg::BCS;
                            3'b110:  cmd = cpuPkg::BNE;
                            default: cmd = cpuPkg::BEQ;
                        endcase
                    end
                    3'b101: begin
                        addrMode = cpuPkg::ZPGX;
                        cmd      = (aaa == 3'b100) ? cpuPkg::STY : cpuPkg::LDY;
                    end
                    3'b110: begin
                        case (aaa)
                            3'b000:  cmd = cpuPkg::CLC;
                            3'b001:  cmd = cpuPkg::SEC;
                            3'b010:  cmd = cpuPkg::CLI;
                            3'b011:  cmd = cpuPkg::SEI;
                            3'b100:  cmd = cpuPkg::TYA;
                            3'b101:  cmd = cpuPkg::CLV;
                            3'b110:  cmd = cpuPkg::CLD;
                            default: cmd = cpuPkg::SED;
                        endcase
                    end
                    default: begin // 111
                        addrMode = cpuPkg::ABSX;
                        cmd      = cpuPkg::LDY;
                    end
                endcase
            end
            2'b01: begin
                case (bbb)
                    3'b000:  addrMode = cpuPkg::XIND;
                    3'b001:  addrMode = cpuPkg::ZPG;
                    3'b010:  addrMode = cpuPkg::IMM;
                    3'b011:  addrMode = cpuPkg::ABS;
                    3'b100:  addrMode = cpuPkg::INDY;
                    3'b101:  addrMode = cpuPkg::ZPGX;
                    3'b110:  addrMode = cpuPkg::ABSY;
                    default: addrMode = cpuPkg::ABSX;
                endcase
                case (aaa)
                    3'b000:  cmd = cpuPkg::ORA;
                    3'b001:  cmd = cpuPkg::AND;
                    3'b010:  cmd = cpuPkg::EOR;
                    3'b011:  cmd = cpuPkg::ADC;
                    3'b100:  cmd = cpuPkg::STA;
                    3'b101:  cmd = cpuPkg::LDA;
                    3'b110:  cmd = cpuPkg::CMP;
                    default: cmd = cpuPkg::SBC;
                endcase
            end
            default: begin // 10, the unused 11 column lands here too
                cmd = rmwCmd(aaa);
                case (bbb)
                    3'b000: begin
                        cmd      = cpuPkg::LDX;
                        addrMode = cpuPkg::IMM;
                    end
                    3'b001:  addrMode = cpuPkg::ZPG;
                    3'b010: begin
                        case (aaa)
                            3'b000:  cmd = cpuPkg::ASLA;
                            3'b001:  cmd = cpuPkg::ROLA;
                            3'b010:  cmd = cpuPkg::LSRA;
                            3'b011:  cmd = cpuPkg::RORA;
                            3'b100:  cmd = cpuPkg::TXA;
                            3'b101:  cmd = cpuPkg::TAX;
                            3'b110:  cmd = cpuPkg::DEX;
                            default: cmd = cpuPkg::NOP;
                        endcase
                        addrMode = aaa[2] ? cpuPkg::IMPL : cpuPkg::ACC;
                    end
                    3'b011:  addrMode = cpuPkg::ABS;
                    3'b101:  addrMode = (aaa[2:1] == 2'b10) ? cpuPkg::ZPGY : cpuPkg::ZPGX;
                    3'b110:  cmd = (aaa == 3'b100) ? cpuPkg::TXS : cpuPkg::TSX;
                    default: addrMode = (aaa == 3'b101) ? cpuPkg::ABSY : cpuPkg::ABSX;
                endcase
            end
        endcase
    end

endmodule

// File: hw/ramBlock.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module ramBlock (
    input  logic                      clk,
    input  logic                      ramEn,
    input  logic                      ramWe,
    input  logic [`MEM_ADDR_BITS-1:0] ramAddr,
    input  logic [7:0]                ramWdata,
    output logic [7:0]                ramRdata
);

    logic [7:0] mem [`MEM_BYTES];

    always_ff @(posedge clk) begin
        if (ramEn) begin
            if (ramWe) begin
                mem[ramAddr] <= ramWdata;
            end else begin
                ramRdata <= mem[ramAddr]; // valid next cycle
            end
        end
    end

endmodule

// File: verif/cpuTb.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpuTb;

    localparam int WATCHDOG_CYCLES = 20000; // longest program times worst stall, with margin

    logic                      clk;
    logic                      arstN;
    logic                      start;
    logic                      hostReq;
    logic                      hostWe;
    logic [`MEM_ADDR_BITS-1:0] hostAddr;
    logic [7:0]                hostWdata;
    logic [7:0]                hostRdata;
    logic                      busy;
    logic                      done;
    logic                      illegal;

    integer                    seed;
    int                        testErrs;
    int                        passCnt;
    int                        failCnt;
    bit                        stallStop;
    logic [7:0]                prog[$];
    logic [`MEM_ADDR_BITS-1:0] chkAddr[$];
    logic [7:0]                chkData[$];

    cpuTop u_cpuTop (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    task automatic hostWrite(input logic [`MEM_ADDR_BITS-1:0] addr, input logic [7:0] data);
        @(posedge clk);
        #1;
        hostReq   = 1'b1;
        hostWe    = 1'b1;
        hostAddr  = addr;
        hostWdata = data;
        @(posedge clk);
        #1;
        hostReq = 1'b0;
        hostWe  = 1'b0;
    endtask

    task automatic hostRead(input logic [`MEM_ADDR_BITS-1:0] addr, output logic [7:0] data);
        @(posedge clk);
        #1;
        hostReq  = 1'b1;
        hostWe   = 1'b0;
        hostAddr = addr;
        @(posedge clk);
        #1;
        hostReq = 1'b0;
        data    = hostRdata; // registered read lands at this edge
    endtask

    task automatic runProgram(output logic illegalSeen);
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (!done);
        illegalSeen = illegal;
    endtask

    task automatic loadProgram();
        foreach (prog[i]) hostWrite(`RESET_VECTOR + `MEM_ADDR_BITS'(i), prog[i]);
    endtask

    task automatic expectByte(input logic [`MEM_ADDR_BITS-1:0] addr, input logic [7:0] exp,
                              input string name);
        logic [7:0] got;
        hostRead(addr, got);
        assert (got === exp) else begin
            $display("[FAIL] %0t %s: byte %h reads %h, expected %h", $time, name, addr, got, exp);
            testErrs++;
        end
    endtask

    task automatic finishTest(input string name);
        if (testErrs == 0) begin
            passCnt++;
        end else begin
            failCnt++;
        end
        $display("%s: %0d errors", name, testErrs);
        testErrs = 0;
    endtask

    task automatic runAndCheck(input string name, input bit expIllegal, input bit withStalls);
        logic        illegalSeen;
        logic [31:0] r;
        logic [7:0]  junk;
        foreach (chkAddr[i]) hostWrite(chkAddr[i], 8'hEE); // marks bytes the run must write
        stallStop = 1'b0;
        fork
            begin
                runProgram(illegalSeen);
                stallStop = 1'b1;
            end
            while (withStalls && !stallStop) begin
                r = $random(seed);
                if (r[0]) begin
                    hostRead(r[10:1], junk);
                end else begin
                    @(posedge clk);
                end
            end
        join
        assert (illegalSeen === expIllegal) else begin
            $display("[FAIL] %0t %s: illegal is %b, expected %b", $time, name, illegalSeen,
                     expIllegal);
            testErrs++;
        end
        foreach (chkAddr[i]) expectByte(chkAddr[i], chkData[i], name);
        finishTest(name);
    endtask

    initial begin
        logic [`MEM_ADDR_BITS-1:0] wrAddr[16];
        logic [7:0]                wrData[16];
        logic [7:0]                aluExp[6];
        logic [8:0]                sum;
        logic [7:0]                loopCount;
        seed      = 32'h983f3acb;
        testErrs  = 0;
        passCnt   = 0;
        failCnt   = 0;
        arstN     = 1'b0;
        start     = 1'b0;
        hostReq   = 1'b0;
        hostWe    = 1'b0;
        hostAddr  = '0;
        hostWdata = 8'h00;
        repeat (16) @(posedge clk);
        #1;
        arstN = 1'b1;

        for (int i = 0; i < 16; i++) begin
            wrAddr[i] = {6'($random(seed)), 4'(i)}; // low nibble keeps addresses distinct
            wrData[i] = 8'($random(seed));
            hostWrite(wrAddr[i], wrData[i]);
        end
        for (int i = 0; i < 16; i++) expectByte(wrAddr[i], wrData[i], "hostPort");
        finishTest("hostPort");

        // zero page and absolute sources
        hostWrite(10'h010, 8'h11);
        hostWrite(10'h011, 8'h22);
        hostWrite(10'h012, 8'h33);
        hostWrite(10'h330, 8'h44);
        hostWrite(10'h331, 8'h55);
        hostWrite(10'h332, 8'h66);
        prog = {8'hA9, 8'h5A, 8'h85, 8'h40, 8'hA2, 8'hC3, 8'h86, 8'h41, 8'hA0, 8'h7E,
                8'h84, 8'h42, 8'hA5, 8'h10, 8'h8D, 8'h50, 8'h03, 8'hA6, 8'h11, 8'h8E,
                8'h51, 8'h03, 8'hA4, 8'h12, 8'h8C, 8'h52, 8'h03, 8'hAD, 8'h30, 8'h03,
                8'h85, 8'h43, 8'hAE, 8'h31, 8'h03, 8'h86, 8'h44, 8'hAC, 8'h32, 8'h03,
                8'h84, 8'h45, 8'h00};
        loadProgram();
        chkAddr = {10'h040, 10'h041, 10'h042, 10'h350, 10'h351, 10'h352,
                   10'h043, 10'h044, 10'h045};
        chkData = {8'h5A, 8'hC3, 8'h7E, 8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 8'h66};
        runAndCheck("loadStore", 1'b0, 1'b0);

        hostWrite(10'h020, 8'h3F);
        prog = {8'h18, 8'hA9, 8'h9C, 8'h69, 8'h85, 8'h85, 8'h60, 8'h69, 8'h10, 8'h85,
                8'h61, 8'h38, 8'hA9, 8'h40, 8'h65, 8'h20, 8'h85, 8'h62, 8'h29, 8'hF0,
                8'h85, 8'h63, 8'h09, 8'h0F, 8'h85, 8'h64, 8'h49, 8'hFF, 8'h85, 8'h65,
                8'h00};
        loadProgram();
        sum       = 9'h09C + 9'h085; // carry clear
        aluExp[0] = sum[7:0];
        sum       = {1'b0, sum[7:0]} + 9'h010 + {8'd0, sum[8]}; // carry from previous add
        aluExp[1] = sum[7:0];
        sum       = 9'h040 + 9'h03F + 9'd1; // carry set
        aluExp[2] = sum[7:0];
        aluExp[3] = aluExp[2] & 8'hF0;
        aluExp[4] = aluExp[3] | 8'h0F;
        aluExp[5] = aluExp[4] ^ 8'hFF;
        chkAddr = {10'h060, 10'h061, 10'h062, 10'h063, 10'h064, 10'h065};
        chkData = {aluExp[0], aluExp[1], aluExp[2], aluExp[3], aluExp[4], aluExp[5]};
        runAndCheck("alu", 1'b0, 1'b0);

        // counted loop, BEQ with Z clear, JMP over a store
        loopCount = 8'd5;
        prog = {8'hA9, loopCount, 8'hAA, 8'hA0, 8'h00, 8'hC8, 8'hCA, 8'hD0, 8'hFC, 8'h98,
                8'h85, 8'h70, 8'hA9, 8'h01, 8'hF0, 8'h02, 8'h85, 8'h71, 8'h8A, 8'hA8,
                8'h4C, 8'h1A, 8'h02, 8'h85, 8'h72, 8'h00, 8'h84, 8'h73, 8'h00};
        loadProgram();
        chkAddr = {10'h070, 10'h071, 10'h072, 10'h073};
        chkData = {loopCount, 8'h01, 8'hEE, 8'h00};
        runAndCheck("loop", 1'b0, 1'b0);

        // ALU program again under random host traffic
        prog = {8'h18, 8'hA9, 8'h9C, 8'h69, 8'h85, 8'h85, 8'h60, 8'h69, 8'h10, 8'h85,
                8'h61, 8'h38, 8'hA9, 8'h40, 8'h65, 8'h20, 8'h85, 8'h62, 8'h29, 8'hF0,
                8'h85, 8'h63, 8'h09, 8'h0F, 8'h85, 8'h64, 8'h49, 8'hFF, 8'h85, 8'h65,
                8'h00};
        loadProgram();
        chkAddr = {10'h060, 10'h061, 10'h062, 10'h063, 10'h064, 10'h065};
        chkData = {aluExp[0], aluExp[1], aluExp[2], aluExp[3], aluExp[4], aluExp[5]};
        runAndCheck("hostStall", 1'b0, 1'b1);

        prog = {8'hA9, 8'h11, 8'h85, 8'h74, 8'h66, 8'h74, 8'hA9, 8'h22, 8'h85, 8'h75, 8'h00};
        loadProgram();
        chkAddr = {10'h074, 10'h075};
        chkData = {8'h11, 8'hEE}; // marker after ROR stays untouched
        runAndCheck("illegalStop", 1'b1, 1'b0);

        $display("%0d tests passed, %0d failed, %0d assertion failures", passCnt, failCnt,
                 u_cpuTop.u_asserts.failCount);
        if (failCnt == 0 && u_cpuTop.u_asserts.failCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verif/cpuTbAsserts.sv
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpuTbAsserts (
    input logic                      clk,
    input logic                      arstN,
    input logic                      start,
    input logic                      hostReq,
    input logic                      busy,
    input logic                      done,
    input logic                      coreReq,
    input logic                      coreWe,
    input logic [`MEM_ADDR_BITS-1:0] coreAddr,
    input logic                      coreGrant,
    input cpuPkg::seqStateE          seqState
);

    int unsigned failCount = 0; // read by the testbench summary

    donePulse: assert property (@(posedge clk) disable iff (!arstN) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            failCount++;
        end

    // busy drops exactly when the run ends
    busyWithDone: assert property (@(posedge clk) disable iff (!arstN) $fell(busy) == done)
        else begin
            $error("busy and done out of step");
            failCount++;
        end

    // losing to the host freezes the core
    hostPriority: assert property (@(posedge clk) disable iff (!arstN)
        hostReq && coreReq |=> $stable(seqState))
        else begin
            $error("core advanced while the host held the memory port");
            failCount++;
        end

    reqHeld: assert property (@(posedge clk) disable iff (!arstN)
        coreReq && !coreGrant |=> coreReq && $stable(coreAddr) && $stable(coreWe))
        else begin
            $error("core request changed before it was granted");
            failCount++;
        end

    startIdle: assert property (@(posedge clk) disable iff (!arstN)
        $rose(busy) |-> $past(start && seqState == cpuPkg::IDLE))
        else begin
            $error("run started outside the idle state");
            failCount++;
        end

    startTaken: assert property (@(posedge clk) disable iff (!arstN)
        start && seqState == cpuPkg::IDLE |=> busy)
        else begin
            $error("start in idle did not raise busy");
            failCount++;
        end

endmodule

bind cpuTop cpuTbAsserts u_asserts (
    .clk, .arstN, .start, .hostReq, .busy, .done,
    .coreReq, .coreWe, .coreAddr, .coreGrant,
    .seqState (u_coreSequencer.state)
);
